// ==== hdl/pmp_access_pkg.sv ====
`default_nettype none

// Access side types shared by the checker, the access port and the top
package pmp_access_pkg;

  // Physical address width, byte granular
  localparam int PMP_ADDR_W = 34;

  // Privilege of the requester
  // S mode is not modelled and behaves like U
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_EXEC  = 2'b10
  } pmp_acc_e;

  // One check request as seen on the access port
  typedef struct packed {
    logic [PMP_ADDR_W-1:0] addr;
    pmp_acc_e              acc;
    privlvl_e              priv;
  } pmp_access_t;

endpackage

`default_nettype wire

// ==== hdl/pmp_csr_pkg.sv ====
`default_nettype none

// Configuration side types: entry configs, mseccfg and the write port
package pmp_csr_pkg;
  import pmp_access_pkg::*;

  // Number of implemented entries
  localparam int PMP_NUM_REGIONS = 8;
  // NAPOT granularity, 0 gives 4 byte regions
  localparam int PMP_GRANULARITY = 0;

  // Address matching mode, encoded as the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte, same bit layout as the architectural CSR
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // mseccfg low bits: RLB at bit 2, MMWP at bit 1, MML at bit 0
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } mseccfg_t;

  // pmpaddr holds address bits [33:2]
  typedef logic [PMP_ADDR_W-1:2] pmp_addr_t;

  // Complete protection state handed from the register file to the checker
  typedef struct packed {
    pmp_cfg_t  [PMP_NUM_REGIONS-1:0] cfg;
    pmp_addr_t [PMP_NUM_REGIONS-1:0] addr;
    mseccfg_t                        mseccfg;
  } pmp_csr_t;

  // Register selected by a configuration write
  typedef enum logic [1:0] {
    PMP_WR_CFG    = 2'b00,
    PMP_WR_ADDR   = 2'b01,
    PMP_WR_SECCFG = 2'b10
  } pmp_wr_target_e;

  // Write request, index ignored for mseccfg
  typedef struct packed {
    pmp_wr_target_e target;
    logic [2:0]     index;
    logic [31:0]    data;
  } pmp_csr_wr_t;

endpackage

`default_nettype wire

// ==== hdl/pmp_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_file import pmp_csr_pkg::*, pmp_access_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  // Four-phase write port
  input  logic        wr_req_i,
  input  pmp_csr_wr_t wr_i,
  output logic        wr_ack_o,
  output logic [31:0] wr_rdata_o,
  // Live protection state
  output pmp_csr_t    csr_o
);

  pmp_csr_t                   csr_q;
  pmp_csr_t                   csr_d;
  logic [31:0]                rdata_d;
  logic                       wr_en;
  logic                       rlb;
  logic                       any_lock;
  logic [PMP_NUM_REGIONS-1:0] cfg_locked;
  logic [PMP_NUM_REGIONS-1:0] addr_locked;
  pmp_cfg_t                   cfg_wdata;
  mseccfg_t                   sec_wdata;
  logic                       cfg_mml_deny;

  // Write fires once per handshake, on the edge that raises ack
  assign wr_en = wr_req_i && !wr_ack_o;
  assign rlb   = csr_q.mseccfg.rlb;

  // --------------------------------------------------
  // Lock evaluation
  // --------------------------------------------------

  always_comb begin
    any_lock = 1'b0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      any_lock       = any_lock | csr_q.cfg[i].lock;
      cfg_locked[i]  = csr_q.cfg[i].lock && !rlb;
      addr_locked[i] = cfg_locked[i];
    end
    // A locked TOR entry also freezes the address below it
    for (int i = 0; i < PMP_NUM_REGIONS - 1; i++) begin
      if (csr_q.cfg[i+1].lock && (csr_q.cfg[i+1].mode == PMP_MODE_TOR) && !rlb) begin
        addr_locked[i] = 1'b1;
      end
    end
  end

  // Reserved field of pmpcfg reads as zero
  always_comb begin
    cfg_wdata      = pmp_cfg_t'(wr_i.data[7:0]);
    cfg_wdata.zero = 2'b00;
  end

  assign sec_wdata = mseccfg_t'(wr_i.data[2:0]);

  // Under MML no new locked rule may grant M-mode execute
  // Covers L with X and RW other than 11, plus the shared L,W-only rule
  assign cfg_mml_deny = csr_q.mseccfg.mml && !rlb && cfg_wdata.lock &&
                        (cfg_wdata.exec ? !(cfg_wdata.read && cfg_wdata.write) :
                                          (cfg_wdata.write && !cfg_wdata.read));

  // --------------------------------------------------
  // Next state and read-back
  // --------------------------------------------------

  always_comb begin
    csr_d   = csr_q;
    rdata_d = 32'h0;
    case (wr_i.target)
      PMP_WR_CFG: begin
        if (!cfg_locked[wr_i.index] && !cfg_mml_deny) begin
          csr_d.cfg[wr_i.index] = cfg_wdata;
        end
        rdata_d = {24'h0, csr_d.cfg[wr_i.index]};
      end
      PMP_WR_ADDR: begin
        if (!addr_locked[wr_i.index]) begin
          csr_d.addr[wr_i.index] = wr_i.data[PMP_ADDR_W-3:0];
        end
        rdata_d = csr_d.addr[wr_i.index];
      end
      PMP_WR_SECCFG: begin
        // MML and MMWP only ever get set
        csr_d.mseccfg.mml  = csr_q.mseccfg.mml | sec_wdata.mml;
        csr_d.mseccfg.mmwp = csr_q.mseccfg.mmwp | sec_wdata.mmwp;
        // RLB freezes at zero once any entry is locked
        if (rlb || !any_lock) begin
          csr_d.mseccfg.rlb = sec_wdata.rlb;
        end
        rdata_d = {29'h0, csr_d.mseccfg};
      end
      default: begin
        rdata_d = 32'h0;
      end
    endcase
  end

  // Control state and CSR contents
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      csr_q    <= '0;
      wr_ack_o <= 1'b0;
    end else begin
      if (wr_en) begin
        csr_q    <= csr_d;
        wr_ack_o <= 1'b1;
      end else if (!wr_req_i) begin
        wr_ack_o <= 1'b0;
      end
    end
  end

  // Read-back captured with the write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      wr_rdata_o <= rdata_d;
    end
  end

  assign csr_o = csr_q;

  // Ack never rises without a pending request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    (!wr_ack_o && !wr_req_i) |=> !wr_ack_o);

  // Ack stays up for as long as the master holds req
  a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wr_ack_o && wr_req_i) |=> wr_ack_o);

endmodule

`default_nettype wire

// ==== hdl/pmp_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmp_checker import pmp_csr_pkg::*, pmp_access_pkg::*; (
  input  pmp_csr_t    csr_i,
  input  pmp_access_t access_i,
  output logic        fault_o
);

  logic [PMP_ADDR_W-1:2]      acc_word;
  logic                       is_m;
  logic                       is_exec;
  logic [PMP_NUM_REGIONS-1:0] region_match;
  logic [PMP_NUM_REGIONS-1:0] region_fault;
  logic                       default_fault;
  logic                       fault;

  // Word address of the access, matches the pmpaddr unit
  assign acc_word = access_i.addr[PMP_ADDR_W-1:2];
  assign is_m     = (access_i.priv == PRIV_LVL_M);
  assign is_exec  = (access_i.acc == PMP_ACC_EXEC);

  for (genvar r = 0; r < PMP_NUM_REGIONS; r++) begin : g_region
    pmp_cfg_t              cfg;
    logic [PMP_ADDR_W-1:2] tor_lo;
    logic [PMP_ADDR_W-1:2] mask;
    logic                  eq_match;
    logic                  tor_match;
    logic                  basic_ok;
    logic                  mml_ok;

    assign cfg = csr_i.cfg[r];

    // --------------------------------------------------
    // Region matching
    // --------------------------------------------------

    // TOR lower bound comes from the previous entry, zero for entry 0
    if (r == 0) begin : g_first
      assign tor_lo = '0;
    end else begin : g_next
      assign tor_lo = csr_i.addr[r-1];
    end

    // NAPOT mask clears every bit covered by the trailing ones run
    // Bit 2 is always inside the NAPOT block
    always_comb begin : p_mask
      logic ones;
      ones    = 1'b1;
      mask[2] = (cfg.mode != PMP_MODE_NAPOT);
      for (int b = 3; b < PMP_ADDR_W; b++) begin
        ones    = ones & csr_i.addr[r][b-1];
        mask[b] = (cfg.mode != PMP_MODE_NAPOT) || !ones;
      end
    end

    // Compare only above the granule
    assign eq_match = (acc_word[PMP_ADDR_W-1:PMP_GRANULARITY+2] &
                       mask[PMP_ADDR_W-1:PMP_GRANULARITY+2]) ==
                      (csr_i.addr[r][PMP_ADDR_W-1:PMP_GRANULARITY+2] &
                       mask[PMP_ADDR_W-1:PMP_GRANULARITY+2]);

    // Half-open range [tor_lo, addr)
    assign tor_match = (acc_word[PMP_ADDR_W-1:PMP_GRANULARITY+2] >=
                        tor_lo[PMP_ADDR_W-1:PMP_GRANULARITY+2]) &&
                       (acc_word[PMP_ADDR_W-1:PMP_GRANULARITY+2] <
                        csr_i.addr[r][PMP_ADDR_W-1:PMP_GRANULARITY+2]);

    always_comb begin
      case (cfg.mode)
        PMP_MODE_TOR:   region_match[r] = tor_match;
        PMP_MODE_NA4:   region_match[r] = eq_match;
        PMP_MODE_NAPOT: region_match[r] = eq_match;
        default:        region_match[r] = 1'b0;
      endcase
    end

    // --------------------------------------------------
    // Permission rules
    // --------------------------------------------------

    // Plain R/W/X grant for the access type
    assign basic_ok = (access_i.acc == PMP_ACC_READ  && cfg.read)  ||
                      (access_i.acc == PMP_ACC_WRITE && cfg.write) ||
                      (access_i.acc == PMP_ACC_EXEC  && cfg.exec);

    // MML table
    always_comb begin
      if (!cfg.read && cfg.write) begin
        // Shared regions, selected by L and X
        case ({cfg.lock, cfg.exec})
          2'b00:   mml_ok = (access_i.acc == PMP_ACC_READ) ||
                            (access_i.acc == PMP_ACC_WRITE && is_m);
          2'b01:   mml_ok = (access_i.acc == PMP_ACC_READ) ||
                            (access_i.acc == PMP_ACC_WRITE);
          2'b10:   mml_ok = is_exec;
          default: mml_ok = is_exec || (access_i.acc == PMP_ACC_READ && is_m);
        endcase
      end else if (cfg.lock && cfg.read && cfg.write && cfg.exec) begin
        // Shared read-only for every mode
        mml_ok = (access_i.acc == PMP_ACC_READ);
      end else begin
        // Locked rules belong to M, unlocked rules to U
        mml_ok = basic_ok && (is_m ? cfg.lock : !cfg.lock);
      end
    end

    // Without MML an unlocked entry never restricts M
    assign region_fault[r] = csr_i.mseccfg.mml ? !mml_ok :
                             is_m ? (cfg.lock && !basic_ok) :
                                    !basic_ok;
  end

  // --------------------------------------------------
  // Priority resolution
  // --------------------------------------------------

  // No matching entry
  assign default_fault = csr_i.mseccfg.mmwp ? 1'b1 :
                         csr_i.mseccfg.mml  ? (!is_m || is_exec) :
                                              !is_m;

  // Lowest matching entry wins
  always_comb begin
    logic hit;
    hit   = 1'b0;
    fault = default_fault;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (!hit && region_match[i]) begin
        fault = region_fault[i];
        hit   = 1'b1;
      end
    end
  end

  assign fault_o = fault;

  // Resolved fault must be clean whenever the request is
  always_comb begin
    if (!$isunknown(access_i)) begin
      a_fault_known: assert (!$isunknown(fault_o));
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pmp_access_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmp_access_port import pmp_access_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  // Four-phase check port
  input  logic        req_i,
  input  pmp_access_t access_i,
  output logic        ack_o,
  output logic        err_o,
  // Registered request to the checker and its verdict
  output pmp_access_t check_o,
  input  logic        fault_i
);

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    CHECK = 2'b01,
    RESP  = 2'b10
  } port_state_e;

  port_state_e state_q;
  pmp_access_t check_q;
  logic        err_q;

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------

  // IDLE takes the request, CHECK samples the fault, RESP waits for req low
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q <= CHECK;
          end
        end
        CHECK: begin
          // CSR state seen here is the one this check uses
          err_q   <= fault_i;
          state_q <= RESP;
        end
        RESP: begin
          if (!req_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Request held stable for the checker during CHECK
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      check_q <= access_i;
    end
  end

  assign ack_o   = (state_q == RESP);
  assign err_o   = err_q;
  assign check_o = check_q;

  // Ack drops only once the master has released req
  a_ack_release: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(ack_o) |-> $past(!req_i));

endmodule

`default_nettype wire

// ==== hdl/pmp_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmp_subsys import pmp_csr_pkg::*, pmp_access_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  // Configuration write port
  input  logic        cfg_req_i,
  input  pmp_csr_wr_t cfg_wr_i,
  output logic        cfg_ack_o,
  output logic [31:0] cfg_rdata_o,
  // Access check port
  input  logic        acc_req_i,
  input  pmp_access_t acc_i,
  output logic        acc_ack_o,
  output logic        acc_err_o
);

  pmp_csr_t    csr;
  pmp_access_t check_acc;
  logic        check_fault;

  // Entry and mseccfg registers
  pmp_csr_file pmp_csr_file_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wr_req_i   (cfg_req_i),
    .wr_i       (cfg_wr_i),
    .wr_ack_o   (cfg_ack_o),
    .wr_rdata_o (cfg_rdata_o),
    .csr_o      (csr)
  );

  // Single checker sees the live CSR state
  pmp_checker pmp_checker_inst (
    .csr_i    (csr),
    .access_i (check_acc),
    .fault_o  (check_fault)
  );

  // Request capture and response
  pmp_access_port pmp_access_port_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .req_i    (acc_req_i),
    .access_i (acc_i),
    .ack_o    (acc_ack_o),
    .err_o    (acc_err_o),
    .check_o  (check_acc),
    .fault_i  (check_fault)
  );

endmodule

`default_nettype wire

// ==== include/pmp_ref_model.svh ====
`ifndef PMP_REF_MODEL_SVH
`define PMP_REF_MODEL_SVH

// Behavioural PMP model for the testbench
// Needs pmp_csr_pkg and pmp_access_pkg visible where it is included

// Shadow CSR state after one write, same lock rules as the register file
function automatic pmp_csr_t ref_csr_write(input pmp_csr_t s, input pmp_csr_wr_t w);
  pmp_csr_t n;
  pmp_cfg_t c;
  logic     locked;
  logic     any_lock;
  n      = s;
  locked = 1'b0;
  case (w.target)
    PMP_WR_CFG: begin
      c      = pmp_cfg_t'(w.data[7:0]);
      c.zero = 2'b00;
      locked = s.cfg[w.index].lock && !s.mseccfg.rlb;
      // MML refuses new locked rules with M execute
      if (s.mseccfg.mml && !s.mseccfg.rlb && c.lock) begin
        case ({c.read, c.write, c.exec})
          3'b001, 3'b010, 3'b011, 3'b101: locked = 1'b1;
          default: ;
        endcase
      end
      if (!locked) begin
        n.cfg[w.index] = c;
      end
    end
    PMP_WR_ADDR: begin
      locked = s.cfg[w.index].lock;
      if (w.index != 3'd7 && s.cfg[w.index + 3'd1].lock &&
          s.cfg[w.index + 3'd1].mode == PMP_MODE_TOR) begin
        locked = 1'b1;
      end
      if (!locked || s.mseccfg.rlb) begin
        n.addr[w.index] = w.data[PMP_ADDR_W-3:0];
      end
    end
    PMP_WR_SECCFG: begin
      any_lock = 1'b0;
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        any_lock = any_lock | s.cfg[i].lock;
      end
      n.mseccfg.mml  = s.mseccfg.mml | w.data[0];
      n.mseccfg.mmwp = s.mseccfg.mmwp | w.data[1];
      if (s.mseccfg.rlb || !any_lock) begin
        n.mseccfg.rlb = w.data[2];
      end
    end
    default: ;
  endcase
  return n;
endfunction

// Expected read-back, taken from the state after the write
function automatic logic [31:0] ref_csr_rdata(input pmp_csr_t s, input pmp_csr_wr_t w);
  case (w.target)
    PMP_WR_CFG:    return {24'h0, s.cfg[w.index]};
    PMP_WR_ADDR:   return s.addr[w.index];
    PMP_WR_SECCFG: return {29'h0, s.mseccfg};
    default:       return 32'h0;
  endcase
endfunction

// Does entry i cover the byte address
function automatic logic ref_match(input pmp_csr_t s, input int i,
                                   input logic [PMP_ADDR_W-1:0] a);
  logic [35:0] lo;
  logic [35:0] hi;
  logic [35:0] mask;
  int          t;
  hi = {2'b00, s.addr[i], 2'b00};
  case (s.cfg[i].mode)
    PMP_MODE_TOR: begin
      lo = (i == 0) ? 36'h0 : {2'b00, s.addr[i-1], 2'b00};
      return ({2'b00, a} >= lo) && ({2'b00, a} < hi);
    end
    PMP_MODE_NA4:   return a[PMP_ADDR_W-1:2] == s.addr[i];
    PMP_MODE_NAPOT: begin
      // Region size is 8 bytes times two per trailing one
      t = 0;
      while (t < 32 && s.addr[i][t+2]) begin
        t++;
      end
      mask = ~((36'h1 << (t + 3)) - 36'h1);
      return (({2'b00, a} & mask) == (hi & mask));
    end
    default: return 1'b0;
  endcase
endfunction

// Expected fault flag
function automatic logic ref_fault(input pmp_csr_t s, input pmp_access_t a);
  pmp_cfg_t   c;
  logic [5:0] mml_perm;
  logic [2:0] allow;
  logic       is_m;
  is_m = (a.priv == PRIV_LVL_M);
  for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
    if (ref_match(s, i, a.addr)) begin
      c = s.cfg[i];
      if (s.mseccfg.mml) begin
        // Smepmp table, M grant then U grant, each as XWR
        case ({c.lock, c.read, c.write, c.exec})
          4'b0001: mml_perm = 6'b000_100;
          4'b0010: mml_perm = 6'b011_001;
          4'b0011: mml_perm = 6'b011_011;
          4'b0100: mml_perm = 6'b000_001;
          4'b0101: mml_perm = 6'b000_101;
          4'b0110: mml_perm = 6'b000_011;
          4'b0111: mml_perm = 6'b000_111;
          4'b1001: mml_perm = 6'b100_000;
          4'b1010: mml_perm = 6'b100_100;
          4'b1011: mml_perm = 6'b101_100;
          4'b1100: mml_perm = 6'b001_000;
          4'b1101: mml_perm = 6'b101_000;
          4'b1110: mml_perm = 6'b011_000;
          4'b1111: mml_perm = 6'b001_001;
          default: mml_perm = 6'b000_000;
        endcase
        allow = is_m ? mml_perm[5:3] : mml_perm[2:0];
      end else begin
        allow = (is_m && !c.lock) ? 3'b111 : {c.exec, c.write, c.read};
      end
      return !allow[a.acc];
    end
  end
  if (s.mseccfg.mmwp) begin
    return 1'b1;
  end
  if (s.mseccfg.mml) begin
    return !is_m || (a.acc == PMP_ACC_EXEC);
  end
  return !is_m;
endfunction

`endif

// ==== bench/pmp_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmp_subsys_tb import pmp_csr_pkg::*, pmp_access_pkg::*; ();

  // Cycles any single wait may take before it gives up
  localparam int WAIT_LIMIT = 50;

  // One completed transaction as seen on the DUT ports
  typedef struct packed {
    logic        is_wr;
    pmp_csr_wr_t wr;
    pmp_access_t acc;
    logic [31:0] rdata;
    logic        err;
  } obs_t;

  logic        clk;
  logic        rst_n;
  logic        cfg_req;
  pmp_csr_wr_t cfg_wr;
  logic        cfg_ack;
  logic [31:0] cfg_rdata;
  logic        acc_req;
  pmp_access_t acc;
  logic        acc_ack;
  logic        acc_err;

  // Shadow of the DUT CSR state, owned by the compare process
  pmp_csr_t    shadow;
  obs_t        obs_q[$];
  integer      seed;
  int          checks;
  int          errors;
  int          test_checks0;
  int          test_errors0;
  logic        timed_out;

  `include "pmp_ref_model.svh"

  pmp_subsys pmp_subsys_inst (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .cfg_req_i   (cfg_req),
    .cfg_wr_i    (cfg_wr),
    .cfg_ack_o   (cfg_ack),
    .cfg_rdata_o (cfg_rdata),
    .acc_req_i   (acc_req),
    .acc_i       (acc),
    .acc_ack_o   (acc_ack),
    .acc_err_o   (acc_err)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // --------------------------------------------------
  // Compare tasks and the compare process
  // --------------------------------------------------

  task automatic check_csr(input pmp_csr_wr_t w, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED cfg_rdata_o target=%h index=%h data=%h got=%h exp=%h",
               w.target, w.index, w.data, got, exp);
    end
  endtask

  task automatic check_fault(input pmp_access_t a, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED acc_err_o addr=%h acc=%h priv=%h got=%h exp=%h",
               a.addr, a.acc, a.priv, got, exp);
    end
  endtask

  // Replays every observed transaction through the model in order
  initial begin : compare_responses
    obs_t o;
    forever begin
      @(posedge clk);
      while (obs_q.size() > 0) begin
        o = obs_q.pop_front();
        if (o.is_wr) begin
          shadow = ref_csr_write(shadow, o.wr);
          check_csr(o.wr, o.rdata, ref_csr_rdata(shadow, o.wr));
        end else begin
          check_fault(o.acc, o.err, ref_fault(shadow, o.acc));
        end
      end
    end
  end

  // --------------------------------------------------
  // Handshake drivers
  // --------------------------------------------------

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic cfg_write(input pmp_csr_wr_t w);
    obs_t o;
    int   n;
    // Nothing more is driven once a wait has given up
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    cfg_req <= 1'b1;
    cfg_wr  <= w;
    n = 0;
    @(negedge clk);
    while (!cfg_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cfg_ack) begin
      report_timeout("the configuration ack to rise");
    end else begin
      // Read-back is stable while ack is high
      o       = '0;
      o.is_wr = 1'b1;
      o.wr    = w;
      o.rdata = cfg_rdata;
      obs_q.push_back(o);
      @(posedge clk);
      cfg_req <= 1'b0;
      n = 0;
      @(negedge clk);
      while (cfg_ack && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (cfg_ack) begin
        report_timeout("the configuration ack to fall");
      end
    end
  endtask

  task automatic access_check(input pmp_access_t a);
    obs_t o;
    int   n;
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    acc_req <= 1'b1;
    acc     <= a;
    n = 0;
    @(negedge clk);
    while (!acc_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!acc_ack) begin
      report_timeout("the access ack to rise");
    end else begin
      o       = '0;
      o.acc   = a;
      o.err   = acc_err;
      obs_q.push_back(o);
      @(posedge clk);
      acc_req <= 1'b0;
      n = 0;
      @(negedge clk);
      while (acc_ack && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (acc_ack) begin
        report_timeout("the access ack to fall");
      end
    end
  endtask

  // Waits until the compare process has seen every transaction
  task automatic drain_checks();
    int n;
    n = 0;
    @(negedge clk);
    while (obs_q.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (obs_q.size() != 0) begin
      report_timeout("the compare queue to drain");
    end
  endtask

  // Reset held for 4 cycles and the shadow cleared with it
  task automatic reset_dut();
    drain_checks();
    @(posedge clk);
    rst_n   <= 1'b0;
    cfg_req <= 1'b0;
    acc_req <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n  <= 1'b1;
    shadow = '0;
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  function automatic pmp_csr_wr_t make_wr(input pmp_wr_target_e t, input logic [2:0] idx,
                                          input logic [31:0] d);
    pmp_csr_wr_t w;
    w.target = t;
    w.index  = idx;
    w.data   = d;
    return w;
  endfunction

  function automatic pmp_access_t make_access(input logic [PMP_ADDR_W-1:0] a,
                                              input pmp_acc_e k, input privlvl_e p);
    pmp_access_t r;
    r.addr = a;
    r.acc  = k;
    r.priv = p;
    return r;
  endfunction

  // Address first, so a locking cfg write does not freeze it
  task automatic set_entry(input logic [2:0] idx, input logic [7:0] c,
                           input logic [31:0] a);
    cfg_write(make_wr(PMP_WR_ADDR, idx, a));
    cfg_write(make_wr(PMP_WR_CFG, idx, {24'h0, c}));
  endtask

  task automatic write_seccfg(input logic [2:0] d);
    cfg_write(make_wr(PMP_WR_SECCFG, 3'd0, {29'h0, d}));
  endtask

  // Every access type from both privilege levels
  task automatic probe_all(input logic [PMP_ADDR_W-1:0] a);
    privlvl_e p;
    for (int m = 0; m < 2; m++) begin
      p = (m == 1) ? PRIV_LVL_M : PRIV_LVL_U;
      access_check(make_access(a, PMP_ACC_READ, p));
      access_check(make_access(a, PMP_ACC_WRITE, p));
      access_check(make_access(a, PMP_ACC_EXEC, p));
    end
  endtask

  task automatic begin_test();
    test_checks0 = checks;
    test_errors0 = errors;
  endtask

  task automatic end_test(input string name);
    drain_checks();
    $display("Test %s finished: %0d checks, %0d errors", name,
             checks - test_checks0, errors - test_errors0);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic test_reset_state();
    begin_test();
    @(negedge clk);
    checks++;
    if (cfg_ack || acc_ack || acc_err) begin
      errors++;
      $display("After reset an acknowledge or the error output was high");
    end
    probe_all(34'h0);
    probe_all(34'h3_0000_1234);
    // MMWP turns the no-match default into a fault for M too
    write_seccfg(3'b010);
    probe_all(34'h0);
    probe_all(34'h2000);
    // Clearing is ignored so read-back still shows MMWP
    write_seccfg(3'b000);
    probe_all(34'h40);
    end_test("reset_state");
  endtask

  task automatic test_regions();
    begin_test();
    reset_dut();
    // TOR RW from zero, NA4 R, NAPOT X, NAPOT R over entry 0, TOR RWX
    set_entry(3'd0, 8'h0B, 32'h0000_0100);
    set_entry(3'd1, 8'h11, 32'h0000_0400);
    set_entry(3'd2, 8'h1C, 32'h0000_0807);
    set_entry(3'd3, 8'h19, 32'h0000_00FF);
    set_entry(3'd4, 8'h0F, 32'h0000_2000);
    probe_all(34'h0);
    probe_all(34'h3F8);
    probe_all(34'h3FC);
    probe_all(34'h400);
    probe_all(34'h7FC);
    probe_all(34'h800);
    probe_all(34'h1000);
    probe_all(34'h1004);
    probe_all(34'h2000);
    probe_all(34'h203C);
    probe_all(34'h2040);
    probe_all(34'h7FFC);
    probe_all(34'h8000);
    end_test("regions");
  endtask

  task automatic test_locking();
    begin_test();
    reset_dut();
    // Locked TOR read-only entry 1 over [0x400, 0x800)
    set_entry(3'd0, 8'h00, 32'h0000_0100);
    set_entry(3'd1, 8'h89, 32'h0000_0200);
    probe_all(34'h400);
    probe_all(34'h7FC);
    probe_all(34'h100);
    // All of these are expected to be ignored
    cfg_write(make_wr(PMP_WR_CFG, 3'd1, 32'h0000_000F));
    cfg_write(make_wr(PMP_WR_ADDR, 3'd1, 32'h0000_0300));
    cfg_write(make_wr(PMP_WR_ADDR, 3'd0, 32'h0000_0080));
    write_seccfg(3'b100);
    probe_all(34'h400);
    // Same sequence with RLB set before the lock
    reset_dut();
    write_seccfg(3'b100);
    set_entry(3'd0, 8'h00, 32'h0000_0100);
    set_entry(3'd1, 8'h89, 32'h0000_0200);
    cfg_write(make_wr(PMP_WR_CFG, 3'd1, 32'h0000_008F));
    cfg_write(make_wr(PMP_WR_ADDR, 3'd1, 32'h0000_0300));
    cfg_write(make_wr(PMP_WR_ADDR, 3'd0, 32'h0000_0080));
    probe_all(34'h200);
    probe_all(34'hBFC);
    // RLB may still be cleared, after which the lock binds again
    write_seccfg(3'b000);
    cfg_write(make_wr(PMP_WR_CFG, 3'd1, 32'h0000_0000));
    probe_all(34'h200);
    end_test("locking");
  endtask

  task automatic test_mml();
    logic [3:0] lrwx;
    logic [7:0] c;
    begin_test();
    for (int v = 0; v < 16; v++) begin
      reset_dut();
      lrwx = v[3:0];
      // NAPOT mode over bytes 0x0 to 0xFFF
      c = {lrwx[3], 2'b00, 2'b11, lrwx[0], lrwx[1], lrwx[2]};
      set_entry(3'd0, c, 32'h0000_01FF);
      write_seccfg(3'b001);
      probe_all(34'h100);
      probe_all(34'h4000);
      // Same rule written after MML is refused for the M execute cases
      set_entry(3'd1, c, 32'h0000_0BFF);
      probe_all(34'h2800);
    end
    end_test("mml");
  endtask

  task automatic test_random();
    logic [31:0]    r;
    logic [31:0]    d;
    pmp_wr_target_e tgt;
    pmp_acc_e       k;
    begin_test();
    for (int i = 0; i < 200; i++) begin
      // Sticky bits would soon fault everything, so start over now and then
      if (i % 50 == 0) begin
        reset_dut();
      end
      r = $random(seed);
      d = $random(seed);
      if (r[3:0] == 4'h0) begin
        tgt = PMP_WR_SECCFG;
        d   = {29'h0, d[2], d[1] & d[3] & d[4], d[0] & d[5]};
      end else if (r[4]) begin
        tgt = PMP_WR_CFG;
        d   = {24'h0, d[7:0]};
      end else begin
        tgt = PMP_WR_ADDR;
        d   = {20'h0, d[11:0]};
      end
      cfg_write(make_wr(tgt, r[7:5], d));
      for (int j = 0; j < 2; j++) begin
        r = $random(seed);
        k = (r[17:16] == 2'd3) ? PMP_ACC_EXEC : pmp_acc_e'(r[17:16]);
        access_check(make_access({20'h0, r[13:0]}, k,
                                 r[18] ? PRIV_LVL_M : PRIV_LVL_U));
      end
    end
    end_test("random");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin : main_flow
    rst_n     = 1'b0;
    cfg_req   = 1'b0;
    cfg_wr    = '0;
    acc_req   = 1'b0;
    acc       = '0;
    shadow    = '0;
    seed      = 32'hb5e1;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_regions();
    test_locking();
    test_mml();
    test_random();
    drain_checks();
    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pmp_subsys.f ====
+incdir+include
hdl/pmp_access_pkg.sv
hdl/pmp_csr_pkg.sv
hdl/pmp_csr_file.sv
hdl/pmp_checker.sv
hdl/pmp_access_port.sv
hdl/pmp_subsys.sv
bench/pmp_subsys_tb.sv

// ==== Makefile ====
# Verilator flow for the PMP subsystem

VERILATOR ?= verilator
FILELIST  ?= pmp_subsys.f
TB_TOP    ?= pmp_subsys_tb
RTL_TOP   ?= pmp_subsys
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') include/pmp_ref_model.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
